// File: src/xm23_dev_params.svh
`ifndef XM23_DEV_PARAMS_SVH
`define XM23_DEV_PARAMS_SVH

// Device byte addresses, same slots as the board's device memory

// Interval timer
`define XM23_TMR_CSR 4'd0
`define XM23_TMR_DATA 4'd1

// Traffic lights
`define XM23_TL_CSR 4'd6
`define XM23_TL_DATA 4'd7

// Clock cycles per device tick, shared by both devices
`define XM23_PRESCALE 4

// Amber is not programmable
`define XM23_AMBER_TICKS 2

`endif

// File: src/xm23_dev_pkg.sv
package xm23_dev_pkg;

	// Control/status byte as the devices see it
	typedef struct packed {
		logic [1:0] rsv;	// Reads zero
		logic [1:0] phase;	// Light phase, zero in the timer
		logic of;			// Overrun
		logic dba;			// Data available
		logic ie;			// Interrupt enable
		logic en;			// Device enable
	} csr_fields_t;

	// One CSR byte, raw on the bus or split into fields
	typedef union packed {
		logic [7:0] raw;
		csr_fields_t f;
	} dev_csr_u;

	typedef struct packed {
		logic walk;
		logic red;
		logic amber;
		logic green;
	} lights_t;

	typedef enum logic [1:0] {
		PH_RED = 2'd0,
		PH_GREEN = 2'd1,
		PH_AMBER = 2'd2
	} tl_phase_e;

	// Wishbone classic, master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [3:0] adr;
		logic [7:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [7:0] dat;
	} wb_rsp_t;

	// Decoder strobes into one device
	typedef struct packed {
		logic csr_wr;
		logic data_wr;
		logic csr_rd;		// CSR byte is being read, clears dba/of
		logic [7:0] wdat;
	} dev_port_t;

endpackage

// File: src/dev_timer.sv
`include "xm23_dev_params.svh"

module dev_timer (
	input logic clock_i,
	input logic reset_i,
	input xm23_dev_pkg::dev_port_t port_i,
	output xm23_dev_pkg::dev_csr_u csr_o,
	output logic [7:0] data_o,
	output logic irq_flag_o
);
	localparam int PRE_W = $clog2(`XM23_PRESCALE + 1);

	xm23_dev_pkg::dev_csr_u wr_csr;
	logic en_q;
	logic ie_q;
	logic dba_q;
	logic of_q;
	logic dba_n;
	logic of_n;
	logic [7:0] period_q;
	logic [7:0] cnt_q;			// Ticks since last expiry
	logic [PRE_W-1:0] pre_q;
	logic tick;
	logic run;
	logic expire;

	assign wr_csr.raw = port_i.wdat;	// Bus byte decoded as fields

	assign tick = (pre_q == PRE_W'(`XM23_PRESCALE - 1));
	assign run = en_q & ~port_i.csr_wr;	// A CSR write restarts instead
	// Period 0 never fires
	assign expire = run & tick & (period_q != 8'd0) & (cnt_q >= period_q - 8'd1);

	// Read clears first, a coincident expiry still lands
	always_comb begin
		dba_n = port_i.csr_rd ? 1'b0 : dba_q;
		of_n = port_i.csr_rd ? 1'b0 : of_q;
		if (expire) begin
			of_n = of_n | dba_n;
			dba_n = 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			en_q <= 1'b0;
			ie_q <= 1'b0;
			dba_q <= 1'b0;
			of_q <= 1'b0;
			period_q <= 8'd0;
			cnt_q <= 8'd0;
			pre_q <= '0;
		end else begin
			dba_q <= dba_n;
			of_q <= of_n;
			if (port_i.data_wr)
				period_q <= port_i.wdat;
			if (port_i.csr_wr) begin
				en_q <= wr_csr.f.en;	// Only en and ie are writable
				ie_q <= wr_csr.f.ie;
				pre_q <= '0;
				cnt_q <= 8'd0;
			end else if (en_q) begin
				pre_q <= tick ? '0 : pre_q + 1'b1;
				if (expire)
					cnt_q <= 8'd0;
				else if (tick)
					cnt_q <= cnt_q + 8'd1;
			end
		end
	end

	assign csr_o.f = xm23_dev_pkg::csr_fields_t'{
		rsv: 2'b00,
		phase: 2'b00,
		of: of_q,
		dba: dba_q,
		ie: ie_q,
		en: en_q
	};
	assign data_o = period_q;
	assign irq_flag_o = ie_q & dba_q;

endmodule

// File: src/dev_traffic_lights.sv
`include "xm23_dev_params.svh"

module dev_traffic_lights (
	input logic clock_i,
	input logic reset_i,
	input xm23_dev_pkg::dev_port_t port_i,
	input logic button_i,
	output xm23_dev_pkg::dev_csr_u csr_o,
	output logic [7:0] data_o,
	output logic irq_flag_o,
	output xm23_dev_pkg::lights_t lights_o
);
	localparam int PRE_W = $clog2(`XM23_PRESCALE + 1);

	xm23_dev_pkg::dev_csr_u wr_csr;
	xm23_dev_pkg::tl_phase_e phase_q;
	xm23_dev_pkg::tl_phase_e phase_next;
	logic en_q;
	logic ie_q;
	logic dba_q;
	logic of_q;
	logic dba_n;
	logic of_n;
	logic walk_q;
	logic ped_req_q;
	logic [2:0] btn_q;			// Two sync stages plus edge history
	logic [7:0] dwell_q;		// Green and red length in ticks
	logic [7:0] dwell_len;
	logic [7:0] limit;
	logic [7:0] dwell_cnt_q;
	logic [PRE_W-1:0] pre_q;
	logic tick;
	logic press;
	logic run;
	logic phase_done;
	logic enter_red;

	assign wr_csr.raw = port_i.wdat;
	assign press = btn_q[1] & ~btn_q[2];	// Rising edge after sync
	assign tick = (pre_q == PRE_W'(`XM23_PRESCALE - 1));
	assign run = en_q & ~port_i.csr_wr;
	assign dwell_len = (dwell_q == 8'd0) ? 8'd1 : dwell_q;

	// Dwell limit and successor of the current phase
	always_comb begin
		case (phase_q)
			xm23_dev_pkg::PH_GREEN: begin
				limit = dwell_len;
				phase_next = xm23_dev_pkg::PH_AMBER;
			end
			xm23_dev_pkg::PH_AMBER: begin
				limit = 8'(`XM23_AMBER_TICKS);
				phase_next = xm23_dev_pkg::PH_RED;
			end
			default: begin
				limit = dwell_len;
				phase_next = xm23_dev_pkg::PH_GREEN;
			end
		endcase
	end

	assign phase_done = run & tick & (dwell_cnt_q >= limit - 8'd1);
	assign enter_red = phase_done & (phase_q == xm23_dev_pkg::PH_AMBER);

	// Same status rule as the timer, the event being entry to red
	always_comb begin
		dba_n = port_i.csr_rd ? 1'b0 : dba_q;
		of_n = port_i.csr_rd ? 1'b0 : of_q;
		if (enter_red) begin
			of_n = of_n | dba_n;
			dba_n = 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			en_q <= 1'b0;
			ie_q <= 1'b0;
			dba_q <= 1'b0;
			of_q <= 1'b0;
			walk_q <= 1'b0;
			ped_req_q <= 1'b0;
			btn_q <= 3'b000;
			dwell_q <= 8'd0;
			dwell_cnt_q <= 8'd0;
			pre_q <= '0;
			phase_q <= xm23_dev_pkg::PH_RED;
		end else begin
			btn_q <= {btn_q[1:0], button_i};
			dba_q <= dba_n;
			of_q <= of_n;
			if (port_i.data_wr)
				dwell_q <= port_i.wdat;
			if (port_i.csr_wr) begin
				en_q <= wr_csr.f.en;
				ie_q <= wr_csr.f.ie;
				pre_q <= '0;
				dwell_cnt_q <= 8'd0;
				walk_q <= 1'b0;
				// Enabling starts at green, disabling parks on red
				phase_q <= wr_csr.f.en ? xm23_dev_pkg::PH_GREEN : xm23_dev_pkg::PH_RED;
			end else if (en_q) begin
				pre_q <= tick ? '0 : pre_q + 1'b1;
				if (phase_done) begin
					dwell_cnt_q <= 8'd0;
					phase_q <= phase_next;
					walk_q <= enter_red & ped_req_q;	// Walk only for a whole red
				end else if (tick) begin
					dwell_cnt_q <= dwell_cnt_q + 8'd1;
				end
			end
			if (!en_q)
				ped_req_q <= 1'b0;
			else if (enter_red)
				ped_req_q <= press;	// Served now, a fresh press waits
			else if (press)
				ped_req_q <= 1'b1;
		end
	end

	assign csr_o.f = xm23_dev_pkg::csr_fields_t'{
		rsv: 2'b00,
		phase: phase_q,
		of: of_q,
		dba: dba_q,
		ie: ie_q,
		en: en_q
	};
	assign data_o = dwell_q;
	assign irq_flag_o = ie_q & dba_q;

	assign lights_o = xm23_dev_pkg::lights_t'{
		walk: walk_q,
		red: (phase_q == xm23_dev_pkg::PH_RED),
		amber: (phase_q == xm23_dev_pkg::PH_AMBER),
		green: (phase_q == xm23_dev_pkg::PH_GREEN)
	};

endmodule

// File: src/dev_bus_decoder.sv
`include "xm23_dev_params.svh"

module dev_bus_decoder (
	input logic clock_i,
	input logic reset_i,
	input xm23_dev_pkg::wb_req_t wb_req_i,
	input xm23_dev_pkg::dev_csr_u tmr_csr_i,
	input xm23_dev_pkg::dev_csr_u tl_csr_i,
	input logic [7:0] tmr_data_i,
	input logic [7:0] tl_data_i,
	input logic tmr_irq_i,
	input logic tl_irq_i,
	output xm23_dev_pkg::wb_rsp_t wb_rsp_o,
	output xm23_dev_pkg::dev_port_t tmr_port_o,
	output xm23_dev_pkg::dev_port_t tl_port_o,
	output logic irq_o
);
	logic ack_q;
	logic [7:0] rdat_q;
	logic [7:0] rd_byte;
	logic irq_q;
	logic start;				// Cycle before the ack-raising edge
	logic wr;
	logic rd;
	logic sel_tmr_csr;
	logic sel_tmr_data;
	logic sel_tl_csr;
	logic sel_tl_data;

	assign start = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
	assign wr = start & wb_req_i.we;
	assign rd = start & ~wb_req_i.we;

	assign sel_tmr_csr = (wb_req_i.adr == `XM23_TMR_CSR);
	assign sel_tmr_data = (wb_req_i.adr == `XM23_TMR_DATA);
	assign sel_tl_csr = (wb_req_i.adr == `XM23_TL_CSR);
	assign sel_tl_data = (wb_req_i.adr == `XM23_TL_DATA);

	// Unmapped bytes read as zero
	always_comb begin
		rd_byte = 8'h00;
		if (sel_tmr_csr)
			rd_byte = tmr_csr_i.raw;
		else if (sel_tmr_data)
			rd_byte = tmr_data_i;
		else if (sel_tl_csr)
			rd_byte = tl_csr_i.raw;
		else if (sel_tl_data)
			rd_byte = tl_data_i;
	end

	// Strobes are high in the cycle that ends at the ack-raising edge
	assign tmr_port_o = xm23_dev_pkg::dev_port_t'{
		csr_wr: wr & sel_tmr_csr,
		data_wr: wr & sel_tmr_data,
		csr_rd: rd & sel_tmr_csr,
		wdat: wb_req_i.dat
	};
	assign tl_port_o = xm23_dev_pkg::dev_port_t'{
		csr_wr: wr & sel_tl_csr,
		data_wr: wr & sel_tl_data,
		csr_rd: rd & sel_tl_csr,
		wdat: wb_req_i.dat
	};

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			ack_q <= 1'b0;
			irq_q <= 1'b0;
		end else begin
			ack_q <= start;		// One cycle only, start needs ack low
			irq_q <= tmr_irq_i | tl_irq_i;
		end
	end

	// Read byte captured before the device clears its status
	always_ff @(posedge clock_i) begin
		if (start)
			rdat_q <= rd_byte;
	end

	assign wb_rsp_o = xm23_dev_pkg::wb_rsp_t'{
		ack: ack_q,
		dat: rdat_q
	};
	assign irq_o = irq_q;

endmodule

// File: src/xm23_dev_top.sv
module xm23_dev_top (
	input logic clock_i,
	input logic reset_i,
	input xm23_dev_pkg::wb_req_t wb_req_i,
	output xm23_dev_pkg::wb_rsp_t wb_rsp_o,
	input logic button_i,
	output xm23_dev_pkg::lights_t lights_o,
	output logic irq_o
);
	xm23_dev_pkg::dev_port_t tmr_port;
	xm23_dev_pkg::dev_port_t tl_port;
	xm23_dev_pkg::dev_csr_u tmr_csr;
	xm23_dev_pkg::dev_csr_u tl_csr;
	logic [7:0] tmr_data;
	logic [7:0] tl_data;
	logic tmr_irq;
	logic tl_irq;

	dev_bus_decoder decoder (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.wb_req_i(wb_req_i),
		.tmr_csr_i(tmr_csr),
		.tl_csr_i(tl_csr),
		.tmr_data_i(tmr_data),
		.tl_data_i(tl_data),
		.tmr_irq_i(tmr_irq),
		.tl_irq_i(tl_irq),
		.wb_rsp_o(wb_rsp_o),
		.tmr_port_o(tmr_port),
		.tl_port_o(tl_port),
		.irq_o(irq_o)
	);

	dev_timer timer (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.port_i(tmr_port),
		.csr_o(tmr_csr),
		.data_o(tmr_data),
		.irq_flag_o(tmr_irq)
	);

	dev_traffic_lights lights (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.port_i(tl_port),
		.button_i(button_i),	// Raw push button, synced inside
		.csr_o(tl_csr),
		.data_o(tl_data),
		.irq_flag_o(tl_irq),
		.lights_o(lights_o)
	);

endmodule

// File: bench/clock_gen.sv
module clock_gen (
	output logic clock_o,
	output logic reset_o
);
	initial begin
		clock_o = 1'b0;
		forever #2 clock_o = ~clock_o;	// Period of 4
	end

	// Reset spans the first three rising edges
	initial begin
		reset_o = 1'b1;
		repeat (3) @(posedge clock_o);
		reset_o <= 1'b0;
	end
endmodule

// File: bench/tb_xm23_dev.sv
`include "xm23_dev_params.svh"

module tb_xm23_dev;
	localparam int TMR_P = 4;		// Timer period under test
	localparam int TL_D = 3;		// Green and red dwell under test
	localparam int T_EXP = TMR_P * `XM23_PRESCALE;
	localparam int T_GR = TL_D * `XM23_PRESCALE;
	localparam int T_AM = `XM23_AMBER_TICKS * `XM23_PRESCALE;
	// Reset, reset reads, register access, expiry, overrun, lights
	localparam int RUN_CYCLES = 3 + 16 * 3 + 15 * 3 + (T_EXP + 12) + (2 * T_EXP + 12)
		+ (4 * T_GR + 2 * T_AM + 9);
	localparam int LIMIT = RUN_CYCLES + 100;

	logic clock;
	logic reset;
	logic button;
	logic irq;
	xm23_dev_pkg::wb_req_t wb_req;
	xm23_dev_pkg::wb_rsp_t wb_rsp;
	xm23_dev_pkg::lights_t lights;

	int cycle = 0;
	int last_edge;				// Ack-raising edge of the last access
	int checks;
	int mismatches;
	int other_errors;

	// Register shadow whose status bits follow the expected events
	xm23_dev_pkg::dev_csr_u sh_tmr_csr;
	xm23_dev_pkg::dev_csr_u sh_tl_csr;
	logic [7:0] sh_tmr_data;
	logic [7:0] sh_tl_data;

	logic [3:0] adr_q[$];
	logic [7:0] exp_q[$];
	logic [7:0] got_q[$];

	clock_gen clk_rst (.clock_o(clock), .reset_o(reset));

	xm23_dev_top DUT (
		.clock_i(clock),
		.reset_i(reset),
		.wb_req_i(wb_req),
		.wb_rsp_o(wb_rsp),
		.button_i(button),
		.lights_o(lights),
		.irq_o(irq)
	);

	function automatic logic [7:0] model_read(input logic [3:0] adr);
		xm23_dev_pkg::dev_csr_u c;
		c.raw = 8'h00;			// Unmapped
		case (adr)
			`XM23_TMR_CSR: begin
				c.f = sh_tmr_csr.f;
				c.f.rsv = 2'b00;
				c.f.phase = 2'b00;
			end
			`XM23_TMR_DATA: c.raw = sh_tmr_data;
			`XM23_TL_CSR: begin
				c.f = sh_tl_csr.f;
				c.f.rsv = 2'b00;
			end
			`XM23_TL_DATA: c.raw = sh_tl_data;
			default: c.raw = 8'h00;
		endcase
		return c.raw;
	endfunction

	// Only en and ie are writable and enabling the lights starts green
	function automatic void note_write(input logic [3:0] adr, input logic [7:0] dat);
		xm23_dev_pkg::dev_csr_u w;
		w.raw = dat;
		case (adr)
			`XM23_TMR_CSR: begin
				sh_tmr_csr.f.en = w.f.en;
				sh_tmr_csr.f.ie = w.f.ie;
			end
			`XM23_TMR_DATA: sh_tmr_data = dat;
			`XM23_TL_CSR: begin
				sh_tl_csr.f.en = w.f.en;
				sh_tl_csr.f.ie = w.f.ie;
				sh_tl_csr.f.phase = w.f.en ? xm23_dev_pkg::PH_GREEN : xm23_dev_pkg::PH_RED;
			end
			`XM23_TL_DATA: sh_tl_data = dat;
			default: ;
		endcase
	endfunction

	// An event sets dba, or of when dba is still pending
	function automatic xm23_dev_pkg::dev_csr_u after_event(input xm23_dev_pkg::dev_csr_u c);
		xm23_dev_pkg::dev_csr_u n;
		n = c;
		n.f.of = c.f.of | c.f.dba;
		n.f.dba = 1'b1;
		return n;
	endfunction

	function automatic xm23_dev_pkg::lights_t lights_for(input logic [1:0] phase,
		input logic walk);
		xm23_dev_pkg::lights_t l;
		l.walk = walk;
		l.red = (phase == xm23_dev_pkg::PH_RED);
		l.amber = (phase == xm23_dev_pkg::PH_AMBER);
		l.green = (phase == xm23_dev_pkg::PH_GREEN);
		return l;
	endfunction

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("CHECK FAILED t=%0t %s got 8'h%02h expected 8'h%02h", $time, name, got, exp);
		end
	endtask

	task automatic check_csr(input string name, input xm23_dev_pkg::dev_csr_u got,
		input xm23_dev_pkg::dev_csr_u exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("CHECK FAILED t=%0t %s got 8'h%02h expected 8'h%02h (dba %b/%b of %b/%b)",
				$time, name, got.raw, exp.raw, got.f.dba, exp.f.dba, got.f.of, exp.f.of);
		end
	endtask

	task automatic check_lights(input string name, input xm23_dev_pkg::lights_t got,
		input xm23_dev_pkg::lights_t exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("CHECK FAILED t=%0t %s got 4'b%04b expected 4'b%04b", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// Called at a falling edge and returns at one
	task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [7:0] dat,
		output logic [7:0] rdat);
		int waited;
		@(posedge clock);
		wb_req <= xm23_dev_pkg::wb_req_t'{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		@(negedge clock);
		waited = 1;
		while (!wb_rsp.ack) begin
			@(negedge clock);
			waited++;
		end
		if (waited != 2) begin
			other_errors++;
			$display("t=%0t ack came %0d cycles after the request instead of 2", $time, waited);
		end
		rdat = wb_rsp.dat;
		last_edge = cycle;
		@(posedge clock);
		wb_req <= '0;
		@(negedge clock);
		if (wb_rsp.ack) begin
			other_errors++;
			$display("t=%0t ack stayed high for more than one cycle", $time);
		end
	endtask

	task automatic bus_write(input logic [3:0] adr, input logic [7:0] dat);
		logic [7:0] unused;
		bus_cycle(1'b1, adr, dat, unused);
		note_write(adr, dat);
	endtask

	task automatic bus_read(input logic [3:0] adr);
		logic [7:0] got;
		bus_cycle(1'b0, adr, 8'h00, got);
		adr_q.push_back(adr);
		exp_q.push_back(model_read(adr));
		got_q.push_back(got);
		if (adr == `XM23_TMR_CSR) begin
			sh_tmr_csr.f.dba = 1'b0;	// Cleared by the read
			sh_tmr_csr.f.of = 1'b0;
		end
		if (adr == `XM23_TL_CSR) begin
			sh_tl_csr.f.dba = 1'b0;
			sh_tl_csr.f.of = 1'b0;
		end
	endtask

	task automatic wait_cycle(input int n);
		while (cycle < n)
			@(negedge clock);
		if (cycle != n) begin
			other_errors++;
			$display("t=%0t checkpoint at cycle %0d was already passed", $time, n);
		end
	endtask

	task automatic lights_at(input int n, input logic [1:0] phase, input logic walk);
		wait_cycle(n);
		check_lights("lights_o", lights, lights_for(phase, walk));
	endtask

	task automatic press_button();
		@(posedge clock);
		button <= 1'b1;
		repeat (3) @(posedge clock);
		button <= 1'b0;
		@(negedge clock);
	endtask

	always @(posedge clock)
		cycle <= cycle + 1;

	// Compares each completed bus read against the model
	always @(negedge clock) begin : compare_reads
		logic [3:0] adr;
		xm23_dev_pkg::dev_csr_u rd_got;
		xm23_dev_pkg::dev_csr_u rd_exp;
		while (got_q.size() > 0) begin
			adr = adr_q.pop_front();
			rd_got.raw = got_q.pop_front();
			rd_exp.raw = exp_q.pop_front();
			if (adr == `XM23_TMR_CSR || adr == `XM23_TL_CSR)
				check_csr($sformatf("wb_rsp_o.dat csr @%0d", adr), rd_got, rd_exp);
			else
				check_byte($sformatf("wb_rsp_o.dat @%0d", adr), rd_got.raw, rd_exp.raw);
		end
	end

	initial begin : watchdog
		wait (cycle >= LIMIT);
		$display("Timeout after %0d cycles, the tests did not finish", LIMIT);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin : stimulus
		logic [7:0] rnd;
		int w;
		xm23_dev_pkg::dev_csr_u exp_u;
		void'($urandom(32'h71b9));
		wb_req = '0;
		button = 1'b0;
		checks = 0;
		mismatches = 0;
		other_errors = 0;
		sh_tmr_csr.raw = 8'h00;
		sh_tl_csr.raw = 8'h00;
		sh_tmr_data = 8'h00;
		sh_tl_data = 8'h00;
		@(negedge clock);
		while (reset)
			@(negedge clock);

		// State after reset
		check_lights("lights_o", lights, lights_for(xm23_dev_pkg::PH_RED, 1'b0));
		check_bit("irq_o", irq, 1'b0);
		for (int a = 0; a < 16; a++)
			bus_read(4'(a));

		// Data bytes, CSR write masks, unmapped slots
		rnd = 8'($urandom);
		bus_write(`XM23_TMR_DATA, rnd);
		bus_read(`XM23_TMR_DATA);
		rnd = 8'($urandom);
		bus_write(`XM23_TL_DATA, rnd);
		bus_read(`XM23_TL_DATA);
		bus_write(`XM23_TMR_DATA, 8'h00);	// Period 0 keeps the timer silent
		bus_write(`XM23_TMR_CSR, 8'($urandom));
		bus_read(`XM23_TMR_CSR);
		bus_write(`XM23_TMR_CSR, 8'h00);
		bus_write(`XM23_TL_CSR, 8'($urandom));
		bus_read(`XM23_TL_CSR);
		bus_write(`XM23_TL_CSR, 8'h00);
		check_lights("lights_o", lights, lights_for(xm23_dev_pkg::PH_RED, 1'b0));
		bus_write(4'd4, 8'($urandom));
		bus_read(4'd4);
		bus_write(4'd13, 8'($urandom));
		bus_read(4'd13);

		// Timer expiry with interrupt
		bus_write(`XM23_TMR_DATA, 8'(TMR_P));
		bus_write(`XM23_TMR_CSR, 8'h03);
		w = last_edge;
		wait_cycle(w + T_EXP - 1);
		exp_u.raw = model_read(`XM23_TMR_CSR);
		check_csr("timer csr_o", DUT.timer.csr_o, exp_u);
		wait_cycle(w + T_EXP);
		sh_tmr_csr = after_event(sh_tmr_csr);
		exp_u.raw = model_read(`XM23_TMR_CSR);
		check_csr("timer csr_o", DUT.timer.csr_o, exp_u);
		check_bit("irq_o", irq, 1'b0);	// Registered one cycle behind dba
		wait_cycle(w + T_EXP + 1);
		check_bit("irq_o", irq, 1'b1);
		bus_read(`XM23_TMR_CSR);
		check_bit("irq_o", irq, 1'b0);
		bus_read(`XM23_TMR_CSR);

		// Two expiries without a read
		bus_write(`XM23_TMR_CSR, 8'h03);
		w = last_edge;
		wait_cycle(w + 2 * T_EXP + 1);
		sh_tmr_csr = after_event(after_event(sh_tmr_csr));
		check_bit("irq_o", irq, 1'b1);
		bus_read(`XM23_TMR_CSR);
		bus_read(`XM23_TMR_CSR);
		bus_write(`XM23_TMR_CSR, 8'h00);

		// Phase order and dwell
		bus_write(`XM23_TL_DATA, 8'(TL_D));
		bus_write(`XM23_TL_CSR, 8'h03);
		w = last_edge;
		bus_read(`XM23_TL_CSR);
		lights_at(w + T_GR - 1, xm23_dev_pkg::PH_GREEN, 1'b0);
		lights_at(w + T_GR, xm23_dev_pkg::PH_AMBER, 1'b0);
		sh_tl_csr.f.phase = xm23_dev_pkg::PH_AMBER;
		bus_read(`XM23_TL_CSR);
		lights_at(w + T_GR + T_AM - 1, xm23_dev_pkg::PH_AMBER, 1'b0);
		lights_at(w + T_GR + T_AM, xm23_dev_pkg::PH_RED, 1'b0);
		sh_tl_csr.f.phase = xm23_dev_pkg::PH_RED;
		sh_tl_csr = after_event(sh_tl_csr);
		wait_cycle(w + T_GR + T_AM + 1);
		check_bit("irq_o", irq, 1'b1);	// Lights interrupt on entry to red
		bus_read(`XM23_TL_CSR);
		check_bit("irq_o", irq, 1'b0);
		lights_at(w + 2 * T_GR + T_AM - 1, xm23_dev_pkg::PH_RED, 1'b0);
		lights_at(w + 2 * T_GR + T_AM, xm23_dev_pkg::PH_GREEN, 1'b0);
		sh_tl_csr.f.phase = xm23_dev_pkg::PH_GREEN;

		// Pedestrian press during green
		press_button();
		lights_at(w + 3 * T_GR + T_AM - 1, xm23_dev_pkg::PH_GREEN, 1'b0);
		lights_at(w + 3 * T_GR + T_AM, xm23_dev_pkg::PH_AMBER, 1'b0);
		lights_at(w + 3 * T_GR + 2 * T_AM - 1, xm23_dev_pkg::PH_AMBER, 1'b0);
		lights_at(w + 3 * T_GR + 2 * T_AM, xm23_dev_pkg::PH_RED, 1'b1);
		sh_tl_csr.f.phase = xm23_dev_pkg::PH_RED;
		sh_tl_csr = after_event(sh_tl_csr);
		bus_read(`XM23_TL_CSR);
		lights_at(w + 4 * T_GR + 2 * T_AM - 1, xm23_dev_pkg::PH_RED, 1'b1);
		lights_at(w + 4 * T_GR + 2 * T_AM, xm23_dev_pkg::PH_GREEN, 1'b0);
		bus_write(`XM23_TL_CSR, 8'h00);
		check_lights("lights_o", lights, lights_for(xm23_dev_pkg::PH_RED, 1'b0));

		repeat (2) @(negedge clock);	// Drain pending reads
		$display("Checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
			other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end
endmodule

// File: src.f
+incdir+src
src/xm23_dev_pkg.sv
src/dev_timer.sv
src/dev_traffic_lights.sv
src/dev_bus_decoder.sv
src/xm23_dev_top.sv
bench/clock_gen.sv
bench/tb_xm23_dev.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal
TOP := tb_xm23_dev
FILELIST := src.f
OBJ_DIR := obj_dir

SIM := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)
